// ==== bench/ctrl_testdata.txt ====
// fe wb ls st rd lsu irq id dbg ack / expected: fl pc kill halt ak cause dm rq ds
// rd={jump,branch,issue} lsu={busy,intr} irq={req,wu} fl={instr_req,busy,pc_set} ak={irq,dbg,save}
// Boot
0 00 0 0 0 1 0 00 0 0  2 0 0 0 0 000 0 0 1
1 00 0 0 0 1 0 00 0 0  2 0 0 0 0 000 0 0 1
1 00 0 0 0 1 0 00 0 0  7 0 0 0 0 000 0 0 2
1 00 0 0 0 1 0 00 0 0  6 0 0 0 0 000 0 0 2
// Writeback exceptions in priority order
1 E0 0 0 0 1 0 00 0 0  7 3 E 0 1 001 0 0 2
1 B0 0 0 0 1 0 00 0 0  7 3 E 0 1 002 0 0 2
1 98 0 0 0 1 0 00 0 0  7 3 E 0 1 00B 0 0 2
1 88 2 0 0 1 0 00 0 0  7 3 E 0 1 003 0 0 2
1 80 2 0 0 1 0 00 0 0  7 3 E 0 1 007 0 0 2
1 80 1 0 0 1 0 00 0 0  7 3 E 0 1 005 0 0 2
1 00 1 0 0 1 0 00 0 0  6 0 0 0 0 000 0 0 2
// Branch once until issue, jump, jump blocked by jr stall
1 00 0 0 2 1 0 00 0 0  7 2 C 0 0 000 0 0 2
1 00 0 0 2 1 0 00 0 0  6 0 0 0 0 000 0 0 2
1 00 0 0 1 1 0 00 0 0  6 0 0 0 0 000 0 0 2
1 00 0 0 4 1 0 00 0 0  7 1 8 0 0 000 0 0 2
1 00 0 0 5 1 0 00 0 0  6 0 0 0 0 000 0 0 2
1 00 0 4 4 1 0 00 0 0  6 0 0 4 0 000 0 0 2
// Interrupt taken, then held off by the LSU
1 00 0 0 0 1 2 0B 0 0  7 4 F 0 5 10B 0 0 2
1 00 0 0 0 0 2 0B 0 0  6 0 0 4 0 000 0 0 2
// Debug entry, masked irq, exception in debug, dret
1 00 0 0 0 1 0 00 1 0  6 0 0 F 0 000 0 0 2
1 00 0 0 0 1 0 00 0 0  7 5 F 0 2 000 0 0 2
1 00 0 0 0 1 0 00 0 0  6 0 0 0 0 000 1 0 4
1 00 0 0 0 1 2 0B 0 0  6 0 0 0 0 000 1 0 4
1 90 0 0 0 1 0 00 0 0  7 6 E 0 0 00B 1 0 4
1 81 0 0 0 1 0 00 0 0  7 7 E 0 0 000 1 0 4
1 00 0 0 0 1 0 00 0 0  6 0 0 0 0 000 0 0 2
// WFI sleep and wake
1 84 0 0 0 1 0 00 0 0  2 0 0 C 0 000 0 0 2
1 00 0 0 0 1 0 00 0 0  0 0 0 1 0 000 0 0 2
1 00 0 0 0 1 1 00 0 0  2 0 0 1 0 000 0 0 2
1 00 0 0 0 1 0 00 0 0  6 0 0 0 0 000 0 0 2
// Fence.i with busy LSU, irq held, ack, refetch
1 82 0 0 0 3 0 00 0 0  6 0 E 1 0 000 0 0 2
1 82 0 0 0 1 0 00 0 0  6 0 E 1 0 000 0 0 2
1 82 0 0 0 1 2 03 0 0  6 0 E 5 0 000 0 1 2
1 82 0 0 0 1 0 00 0 1  6 0 E 1 0 000 0 1 2
1 82 0 0 0 1 0 00 0 0  7 8 E 0 0 000 0 0 2
1 00 0 0 0 1 0 00 0 0  6 0 0 0 0 000 0 0 2
// End of vectors
FFF

// ==== ctrl_top.f ====
+incdir+include
src/ctrl_pkg.sv
src/ctrl_wb_decode.sv
src/ctrl_trap_arbiter.sv
src/ctrl_fencei.sv
src/ctrl_main_fsm.sv
src/ctrl_debug_status.sv
src/ctrl_top.sv
bench/ctrl_assertions.sv
bench/ctrl_tb.sv

// ==== bench/ctrl_tb.sv ====
/*
  Controller testbench
  Replays per-cycle vectors from the test data file against the
  controller top level and compares every output 10 ns before
  the next rising edge
*/
`timescale 1ns/1ps

`include "ctrl_settings.svh"

module ctrl_tb;

  localparam int CLK_HALF   = 50;
  localparam int MAX_LINES  = 64;
  // Ten stimulus columns followed by nine expected columns
  localparam int COLS       = 19;
  localparam int FALL_LIMIT = 4 * CLK_HALF;
  localparam logic [11:0] END_MARK = 12'hFFF;

  logic                        clk;
  logic                        rst_n;
  logic                        fetch_enable;
  ctrl_pkg::wb_pipe_t          wb_pipe;
  ctrl_pkg::mpu_status_e       lsu_status;
  ctrl_pkg::stall_t            stall;
  logic                        jump_id;
  logic                        branch_ex;
  logic                        if_issue;
  logic                        lsu_busy;
  logic                        lsu_interruptible;
  logic                        irq_req;
  logic [`CTRL_IRQ_ID_W-1:0]   irq_id;
  logic                        irq_wu;
  logic                        debug_req;
  logic                        fencei_flush_ack;
  ctrl_pkg::ctrl_out_t         ctrl_out;
  logic                        fencei_flush_req;
  ctrl_pkg::debug_state_e      debug_status;

  logic [11:0] vec_mem [0:MAX_LINES*COLS-1];
  int          line_no;

  ctrl_top i_ctrl_top (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_enable_i      (fetch_enable),
    .wb_pipe_i           (wb_pipe),
    .lsu_status_i        (lsu_status),
    .stall_i             (stall),
    .jump_id_i           (jump_id),
    .branch_ex_i         (branch_ex),
    .if_issue_i          (if_issue),
    .lsu_busy_i          (lsu_busy),
    .lsu_interruptible_i (lsu_interruptible),
    .irq_req_i           (irq_req),
    .irq_id_i            (irq_id),
    .irq_wu_i            (irq_wu),
    .debug_req_i         (debug_req),
    .fencei_flush_ack_i  (fencei_flush_ack),
    .ctrl_o              (ctrl_out),
    .fencei_flush_req_o  (fencei_flush_req),
    .debug_status_o      (debug_status)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // Bounded poll for a 1 to 0 transition of clk
  task automatic wait_fall();
    int   waited;
    logic prev;
    waited = 0;
    do begin
      prev = clk;
      #1;
      waited++;
      if (waited > FALL_LIMIT) begin
        $display("Timeout: no falling clock edge within %0d ns at line %0d", FALL_LIMIT,
                 line_no);
        abort_run();
      end
    end while (!(prev === 1'b1 && clk === 1'b0));
  endtask

  task automatic compare_ctrl(input string name, input ctrl_pkg::ctrl_out_t exp,
                              input ctrl_pkg::ctrl_out_t got);
    if (got !== exp) begin
      $display("CHECK FAILED time=%0t line=%0d %s expected=%h got=%h", $time, line_no,
               name, exp, got);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      $display("CHECK FAILED time=%0t line=%0d %s expected=%b got=%b", $time, line_no,
               name, exp, got);
      abort_run();
    end
  endtask

  task automatic compare_status(input string name, input ctrl_pkg::debug_state_e exp,
                                input ctrl_pkg::debug_state_e got);
    if (got !== exp) begin
      $display("CHECK FAILED time=%0t line=%0d %s expected=%b got=%b", $time, line_no,
               name, exp, got);
      abort_run();
    end
  endtask

  // Bound checker in the main FSM counts its own failures
  task automatic check_assertions();
    if (i_ctrl_top.i_main_fsm.i_ctrl_assertions.fail_count != 0) begin
      $display("Controller assertion failed during the cycle of line %0d", line_no);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // Vector handling
  ////////////////////////////////////////

  task automatic apply_vector(input int base);
    fetch_enable = vec_mem[base][0];
    wb_pipe      = ctrl_pkg::wb_pipe_t'(vec_mem[base+1][7:0]);
    lsu_status   = ctrl_pkg::mpu_status_e'(vec_mem[base+2][1:0]);
    stall        = ctrl_pkg::stall_t'(vec_mem[base+3][2:0]);
    {jump_id, branch_ex, if_issue}  = vec_mem[base+4][2:0];
    {lsu_busy, lsu_interruptible}   = vec_mem[base+5][1:0];
    {irq_req, irq_wu}               = vec_mem[base+6][1:0];
    irq_id           = vec_mem[base+7][`CTRL_IRQ_ID_W-1:0];
    debug_req        = vec_mem[base+8][0];
    fencei_flush_ack = vec_mem[base+9][0];
  endtask

  // Expected fields grouped per column and rebuilt into the DUT struct
  task automatic check_vector(input int base);
    ctrl_pkg::ctrl_out_t exp_ctrl;
    exp_ctrl = '0;
    {exp_ctrl.instr_req, exp_ctrl.ctrl_busy, exp_ctrl.pc_set} = vec_mem[base+10][2:0];
    exp_ctrl.pc_mux = ctrl_pkg::pc_mux_e'(vec_mem[base+11][3:0]);
    {exp_ctrl.kill_if, exp_ctrl.kill_id, exp_ctrl.kill_ex, exp_ctrl.kill_wb} =
      vec_mem[base+12][3:0];
    {exp_ctrl.halt_if, exp_ctrl.halt_id, exp_ctrl.halt_ex, exp_ctrl.halt_wb} =
      vec_mem[base+13][3:0];
    {exp_ctrl.irq_ack, exp_ctrl.dbg_ack, exp_ctrl.csr_save_cause} = vec_mem[base+14][2:0];
    exp_ctrl.csr_cause  = vec_mem[base+15][8:0];
    exp_ctrl.debug_mode = vec_mem[base+16][0];
    compare_ctrl("ctrl_o", exp_ctrl, ctrl_out);
    compare_bit("fencei_flush_req_o", vec_mem[base+17][0], fencei_flush_req);
    compare_status("debug_status_o", ctrl_pkg::debug_state_e'(vec_mem[base+18][2:0]),
                   debug_status);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n             = 1'b0;
    fetch_enable      = 1'b0;
    wb_pipe           = '0;
    lsu_status        = ctrl_pkg::MPU_OK;
    stall             = '0;
    jump_id           = 1'b0;
    branch_ex         = 1'b0;
    if_issue          = 1'b0;
    lsu_busy          = 1'b0;
    lsu_interruptible = 1'b1;
    irq_req           = 1'b0;
    irq_id            = '0;
    irq_wu            = 1'b0;
    debug_req         = 1'b0;
    fencei_flush_ack  = 1'b0;
    line_no           = 0;

    $readmemh("bench/ctrl_testdata.txt", vec_mem);

    // Four rising edges under reset
    repeat (4) begin
      wait_fall();
    end
    rst_n = 1'b1;

    while (line_no < MAX_LINES && vec_mem[line_no*COLS] !== END_MARK) begin
      apply_vector(line_no * COLS);
      #(CLK_HALF - 10);
      check_vector(line_no * COLS);
      wait_fall();
      check_assertions();
      line_no++;
    end

    if (line_no == MAX_LINES) begin
      $display("Test data has no end marker within %0d lines", MAX_LINES);
      abort_run();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== bench/ctrl_assertions.sv ====
/*
  Controller assertions
  Bound into the main FSM to watch redirects, sleep, debug
  entry and the fence.i hold on writeback
*/
`timescale 1ns/1ps

module ctrl_assertions (
  input logic                  clk,
  input logic                  rst_n,
  input ctrl_pkg::ctrl_state_e state_i,
  input ctrl_pkg::ctrl_out_t   ctrl_i,
  input logic                  fencei_start_i,
  input logic                  fencei_done_i
);

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  // A redirect picks a defined PC source that fits the state
  // Boot and debug entry vectors belong to their own states
  a_pc_legal: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.pc_set |-> (!$isunknown(ctrl_i.pc_mux) && ctrl_i.pc_mux <= ctrl_pkg::PC_FENCEI &&
      ((ctrl_i.pc_mux == ctrl_pkg::PC_BOOT) == (state_i == ctrl_pkg::BOOT_SET)) &&
      ((ctrl_i.pc_mux == ctrl_pkg::PC_TRAP_DBD) == (state_i == ctrl_pkg::DEBUG_TAKEN))))
    else begin
      fail_count++;
      $error("pc_set with an undefined pc_mux or a pc_mux that does not fit the state");
    end

  // Sleeping core keeps its pipeline intact
  a_sleep_no_kill: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == ctrl_pkg::SLEEP) |->
      !(ctrl_i.kill_if || ctrl_i.kill_id || ctrl_i.kill_ex || ctrl_i.kill_wb))
    else begin
      fail_count++;
      $error("kill raised while in SLEEP");
    end

  a_dbg_ack_state: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.dbg_ack |-> (state_i == ctrl_pkg::DEBUG_TAKEN))
    else begin
      fail_count++;
      $error("dbg_ack outside DEBUG_TAKEN");
    end

  // Pending flush keeps WB held until done unless a trap discards WB
  a_fencei_hold: assert property (@(posedge clk) disable iff (!rst_n)
    fencei_start_i |=> (fencei_done_i || ctrl_i.halt_wb || ctrl_i.kill_wb))
    else begin
      fail_count++;
      $error("fence.i released writeback before the flush finished");
    end

endmodule

bind ctrl_main_fsm ctrl_assertions i_ctrl_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .state_i        (state_q),
  .ctrl_i         (ctrl_o),
  .fencei_start_i (fencei_start_o),
  .fencei_done_i  (fencei_done_i)
);

// ==== src/ctrl_top.sv ====
/*
  Pipeline controller top
  Connects the WB decoder, trap arbiter, main FSM,
  fence.i handshake and debug status tracker
*/
`timescale 1ns/1ps

`include "ctrl_settings.svh"

module ctrl_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      fetch_enable_i,
  input  ctrl_pkg::wb_pipe_t        wb_pipe_i,
  input  ctrl_pkg::mpu_status_e     lsu_status_i,
  input  ctrl_pkg::stall_t          stall_i,
  input  logic                      jump_id_i,
  input  logic                      branch_ex_i,
  input  logic                      if_issue_i,
  input  logic                      lsu_busy_i,
  input  logic                      lsu_interruptible_i,
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  logic                      irq_wu_i,
  input  logic                      debug_req_i,
  input  logic                      fencei_flush_ack_i,
  output ctrl_pkg::ctrl_out_t       ctrl_o,
  output logic                      fencei_flush_req_o,
  output ctrl_pkg::debug_state_e    debug_status_o
);

  ctrl_pkg::wb_event_t wb_event;
  ctrl_pkg::trap_req_t trap_req;
  logic                fencei_start;
  logic                fencei_done;
  logic                fencei_ongoing;
  logic                debug_mode_next;
  logic                boot;

  ////////////////////////////////////////
  // Decision stages
  ////////////////////////////////////////

  ctrl_wb_decode i_wb_decode (
    .wb_pipe_i    (wb_pipe_i),
    .lsu_status_i (lsu_status_i),
    .wb_event_o   (wb_event)
  );

  ctrl_trap_arbiter i_trap_arbiter (
    .clk                 (clk),
    .rst_n               (rst_n),
    .debug_req_i         (debug_req_i),
    .irq_req_i           (irq_req_i),
    .irq_id_i            (irq_id_i),
    .irq_wu_i            (irq_wu_i),
    .lsu_interruptible_i (lsu_interruptible_i),
    .fencei_ongoing_i    (fencei_ongoing),
    .debug_mode_i        (ctrl_o.debug_mode),
    .trap_req_o          (trap_req)
  );

  // Flush handshake towards the instruction cache
  ctrl_fencei i_fencei (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (fencei_start),
    .lsu_busy_i  (lsu_busy_i),
    .flush_ack_i (fencei_flush_ack_i),
    .flush_req_o (fencei_flush_req_o),
    .done_o      (fencei_done),
    .ongoing_o   (fencei_ongoing)
  );

  ctrl_main_fsm i_main_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .wb_event_i        (wb_event),
    .trap_req_i        (trap_req),
    .stall_i           (stall_i),
    .jump_id_i         (jump_id_i),
    .branch_ex_i       (branch_ex_i),
    .if_issue_i        (if_issue_i),
    .fencei_done_i     (fencei_done),
    .ctrl_o            (ctrl_o),
    .fencei_start_o    (fencei_start),
    .debug_mode_next_o (debug_mode_next),
    .boot_o            (boot)
  );

  ctrl_debug_status i_debug_status (
    .clk               (clk),
    .rst_n             (rst_n),
    .debug_mode_next_i (debug_mode_next),
    .boot_i            (boot),
    .status_o          (debug_status_o)
  );

endmodule

// ==== src/ctrl_debug_status.sv ====
/*
  Debug run status
  One-hot havereset/running/halted as seen by the debug module
*/
`timescale 1ns/1ps

module ctrl_debug_status (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   debug_mode_next_i,
  input  logic                   boot_i,
  output ctrl_pkg::debug_state_e status_o
);

  ctrl_pkg::debug_state_e status_n;

  always_comb begin
    status_n = status_o;
    unique case (status_o)
      // Debug entry before boot goes straight to halted
      ctrl_pkg::HAVERESET: begin
        if (debug_mode_next_i) begin
          status_n = ctrl_pkg::HALTED;
        end else if (boot_i) begin
          status_n = ctrl_pkg::RUNNING;
        end
      end
      ctrl_pkg::RUNNING: begin
        if (debug_mode_next_i) begin
          status_n = ctrl_pkg::HALTED;
        end
      end
      ctrl_pkg::HALTED: begin
        if (!debug_mode_next_i) begin
          status_n = ctrl_pkg::RUNNING;
        end
      end
      default: status_n = ctrl_pkg::HAVERESET;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      status_o <= ctrl_pkg::HAVERESET;
    end else begin
      status_o <= status_n;
    end
  end

endmodule

// ==== src/ctrl_main_fsm.sv ====
/*
  Main controller FSM
  Sequences boot, traps, debug entry, sleep, fence.i and
  redirects, and drives the kill, halt and PC controls
*/
`timescale 1ns/1ps

`include "ctrl_settings.svh"

module ctrl_main_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                fetch_enable_i,
  input  ctrl_pkg::wb_event_t wb_event_i,
  input  ctrl_pkg::trap_req_t trap_req_i,
  input  ctrl_pkg::stall_t    stall_i,
  input  logic                jump_id_i,
  input  logic                branch_ex_i,
  input  logic                if_issue_i,
  input  logic                fencei_done_i,
  output ctrl_pkg::ctrl_out_t ctrl_o,
  output logic                fencei_start_o,
  output logic                debug_mode_next_o,
  output logic                boot_o
);

  ctrl_pkg::ctrl_state_e state_q;
  ctrl_pkg::ctrl_state_e state_n;
  logic                  debug_mode_q;
  logic                  branch_taken_q;
  logic                  branch_taken_n;
  logic                  jump_taken;
  logic                  branch_taken;

  // Redirects fire once per target until IF issues again
  assign jump_taken   = jump_id_i && !stall_i.jr_stall && !branch_taken_q;
  assign branch_taken = branch_ex_i && !branch_taken_q;

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////
  always_comb begin
    state_n           = state_q;
    debug_mode_next_o = debug_mode_q;
    branch_taken_n    = branch_taken_q;
    fencei_start_o    = 1'b0;
    ctrl_o            = '0;
    ctrl_o.instr_req  = 1'b1;
    ctrl_o.ctrl_busy  = 1'b1;
    ctrl_o.pc_mux     = ctrl_pkg::PC_BOOT;
    // Hazards, or a trap waiting on the LSU
    ctrl_o.halt_id    = (|stall_i) || trap_req_i.hold_id;
    ctrl_o.debug_mode = debug_mode_q;

    unique case (state_q)
      ctrl_pkg::RESET: begin
        ctrl_o.instr_req = 1'b0;
        if (fetch_enable_i) begin
          state_n = ctrl_pkg::BOOT_SET;
        end
      end
      // Separate cycle keeps fetch_enable_i off the fetch path
      ctrl_pkg::BOOT_SET: begin
        ctrl_o.pc_set = 1'b1;
        state_n       = ctrl_pkg::FUNCTIONAL;
      end
      ctrl_pkg::FUNCTIONAL: begin
        if (trap_req_i.take_debug) begin
          // Freeze everything, kill happens in DEBUG_TAKEN
          ctrl_o.halt_if = 1'b1;
          ctrl_o.halt_id = 1'b1;
          ctrl_o.halt_ex = 1'b1;
          ctrl_o.halt_wb = 1'b1;
          state_n        = ctrl_pkg::DEBUG_TAKEN;
        end else if (trap_req_i.take_irq) begin
          ctrl_o.kill_if = 1'b1;
          ctrl_o.kill_id = 1'b1;
          ctrl_o.kill_ex = 1'b1;
          ctrl_o.kill_wb = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_mux  = ctrl_pkg::PC_TRAP_IRQ;
          ctrl_o.irq_ack = 1'b1;
          ctrl_o.csr_save_cause           = 1'b1;
          ctrl_o.csr_cause.interrupt      = 1'b1;
          ctrl_o.csr_cause.exception_code =
            {{(`CTRL_EXC_CODE_W - `CTRL_IRQ_ID_W){1'b0}}, trap_req_i.irq_id};
        end else if (wb_event_i.exception) begin
          // WB write enables are already suppressed
          ctrl_o.kill_if = 1'b1;
          ctrl_o.kill_id = 1'b1;
          ctrl_o.kill_ex = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_mux  = debug_mode_q ? ctrl_pkg::PC_TRAP_DBE : ctrl_pkg::PC_TRAP_EXC;
          // No CSR update inside debug mode
          ctrl_o.csr_save_cause           = !debug_mode_q;
          ctrl_o.csr_cause.exception_code = wb_event_i.exc_code;
        end else if (wb_event_i.wfi) begin
          ctrl_o.halt_if   = 1'b1;
          ctrl_o.halt_id   = 1'b1;
          ctrl_o.instr_req = 1'b0;
          state_n          = ctrl_pkg::SLEEP;
        end else if (wb_event_i.fencei) begin
          ctrl_o.kill_if = 1'b1;
          ctrl_o.kill_id = 1'b1;
          ctrl_o.kill_ex = 1'b1;
          if (fencei_done_i) begin
            // Handshake complete, refetch after the fence.i
            ctrl_o.pc_set = 1'b1;
            ctrl_o.pc_mux = ctrl_pkg::PC_FENCEI;
          end else begin
            // Back-pressure while the flush runs
            ctrl_o.halt_wb = 1'b1;
            fencei_start_o = 1'b1;
          end
        end else if (wb_event_i.dret) begin
          ctrl_o.kill_if    = 1'b1;
          ctrl_o.kill_id    = 1'b1;
          ctrl_o.kill_ex    = 1'b1;
          ctrl_o.pc_set     = 1'b1;
          ctrl_o.pc_mux     = ctrl_pkg::PC_DRET;
          debug_mode_next_o = 1'b0;
        end else if (branch_taken) begin
          ctrl_o.kill_if = 1'b1;
          ctrl_o.kill_id = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_mux  = ctrl_pkg::PC_BRANCH;
          branch_taken_n = 1'b1;
        end else if (jump_taken) begin
          ctrl_o.kill_if = 1'b1;
          ctrl_o.pc_set  = 1'b1;
          ctrl_o.pc_mux  = ctrl_pkg::PC_JUMP;
          branch_taken_n = 1'b1;
        end
      end
      ctrl_pkg::SLEEP: begin
        ctrl_o.ctrl_busy = 1'b0;
        ctrl_o.instr_req = 1'b0;
        ctrl_o.halt_wb   = 1'b1;
        if (trap_req_i.wake) begin
          ctrl_o.ctrl_busy = 1'b1;
          state_n          = ctrl_pkg::FUNCTIONAL;
        end
      end
      ctrl_pkg::DEBUG_TAKEN: begin
        ctrl_o.dbg_ack    = 1'b1;
        ctrl_o.pc_set     = 1'b1;
        ctrl_o.pc_mux     = ctrl_pkg::PC_TRAP_DBD;
        ctrl_o.kill_if    = 1'b1;
        ctrl_o.kill_id    = 1'b1;
        ctrl_o.kill_ex    = 1'b1;
        ctrl_o.kill_wb    = 1'b1;
        debug_mode_next_o = 1'b1;
        state_n           = ctrl_pkg::FUNCTIONAL;
      end
      default: begin
        ctrl_o.instr_req = 1'b0;
        state_n          = ctrl_pkg::RESET;
      end
    endcase

    // New instruction out of IF rearms redirects
    if (branch_taken_q && if_issue_i) begin
      branch_taken_n = 1'b0;
    end
  end

  // Leaving RESET, watched by the debug status tracker
  assign boot_o = (state_q == ctrl_pkg::RESET) && (state_n == ctrl_pkg::BOOT_SET);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= ctrl_pkg::RESET;
      debug_mode_q   <= 1'b0;
      branch_taken_q <= 1'b0;
    end else begin
      state_q        <= state_n;
      debug_mode_q   <= debug_mode_next_o;
      branch_taken_q <= branch_taken_n;
    end
  end

endmodule

// ==== src/ctrl_fencei.sv ====
/*
  Fence.i flush handshake
  Request flop towards the cache plus a registered
  request-and-acknowledge flop that marks completion
*/
`timescale 1ns/1ps

module ctrl_fencei (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  input  logic lsu_busy_i,
  input  logic flush_ack_i,
  output logic flush_req_o,
  output logic done_o,
  output logic ongoing_o
);

  logic handshake;

  assign handshake = flush_req_o && flush_ack_i;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      flush_req_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      // Ack only counts while the request is up
      done_o <= handshake;
      // Clear wins over a new start in the same cycle
      if (handshake) begin
        flush_req_o <= 1'b0;
      end else if (start_i && !lsu_busy_i) begin
        flush_req_o <= 1'b1;
      end
    end
  end

  // Blocks traps until the fence.i retires
  assign ongoing_o = flush_req_o || done_o;

endmodule

// ==== src/ctrl_trap_arbiter.sv ====
/*
  Trap arbiter
  Keeps the sticky external debug request and decides whether
  a debug entry or an interrupt may be taken this cycle
*/
`timescale 1ns/1ps

`include "ctrl_settings.svh"

module ctrl_trap_arbiter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      debug_req_i,
  input  logic                      irq_req_i,
  input  logic [`CTRL_IRQ_ID_W-1:0] irq_id_i,
  input  logic                      irq_wu_i,
  input  logic                      lsu_interruptible_i,
  input  logic                      fencei_ongoing_i,
  input  logic                      debug_mode_i,
  output ctrl_pkg::trap_req_t       trap_req_o
);

  logic debug_req_q;
  logic pending_debug;
  logic pending_irq;
  logic trap_allowed;

  // Sticky request, a single-cycle pulse is never lost
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q <= 1'b0;
    end else if (debug_req_i) begin
      debug_req_q <= 1'b1;
    end else if (debug_mode_i) begin
      debug_req_q <= 1'b0;
    end
  end

  // Both sources are masked once in debug mode
  assign pending_debug = (debug_req_i || debug_req_q) && !debug_mode_i;
  assign pending_irq   = irq_req_i && !debug_mode_i;

  // LSU must be killable and any fence.i handshake must finish first
  assign trap_allowed = lsu_interruptible_i && !fencei_ongoing_i;

  // Debug ranks above interrupts
  assign trap_req_o.take_debug = pending_debug && trap_allowed;
  assign trap_req_o.take_irq   = pending_irq && trap_allowed && !pending_debug;

  // Stall ID so an interruptible bubble forms in WB
  assign trap_req_o.hold_id = (pending_debug || pending_irq) && !trap_allowed;

  assign trap_req_o.irq_id = irq_id_i;
  assign trap_req_o.wake   = irq_wu_i || debug_mode_i;

endmodule

// ==== src/ctrl_wb_decode.sv ====
/*
  Writeback decoder
  Turns the instruction in WB into qualified events and picks
  the exception cause by fixed priority
*/
`timescale 1ns/1ps

module ctrl_wb_decode (
  input  ctrl_pkg::wb_pipe_t    wb_pipe_i,
  input  ctrl_pkg::mpu_status_e lsu_status_i,
  output ctrl_pkg::wb_event_t   wb_event_o
);

  logic lsu_fault;
  logic any_fault;

  // Load or store blocked by the MPU
  assign lsu_fault = (lsu_status_i != ctrl_pkg::MPU_OK);

  // Every source of a synchronous trap
  assign any_fault = wb_pipe_i.instr_fault || wb_pipe_i.illegal || wb_pipe_i.ecall ||
                     wb_pipe_i.ebreak || lsu_fault;

  ////////////////////////////////////////
  // Event qualification
  ////////////////////////////////////////

  assign wb_event_o.exception = any_fault && wb_pipe_i.instr_valid;
  assign wb_event_o.wfi       = wb_pipe_i.wfi && wb_pipe_i.instr_valid;
  assign wb_event_o.fencei    = wb_pipe_i.fencei && wb_pipe_i.instr_valid;
  assign wb_event_o.dret      = wb_pipe_i.dret && wb_pipe_i.instr_valid;

  // Cause priority, fetch side first
  // Store fault wins over load fault
  assign wb_event_o.exc_code =
    wb_pipe_i.instr_fault            ? ctrl_pkg::INSTR_FAULT  :
    wb_pipe_i.illegal                ? ctrl_pkg::ILLEGAL_INSN :
    wb_pipe_i.ecall                  ? ctrl_pkg::ECALL_MMODE  :
    wb_pipe_i.ebreak                 ? ctrl_pkg::BREAKPOINT   :
    (lsu_status_i == ctrl_pkg::MPU_WR_FAULT) ? ctrl_pkg::STORE_FAULT :
    ctrl_pkg::LOAD_FAULT;

endmodule

// ==== src/ctrl_pkg.sv ====
/*
  Controller package
  States, PC selects, cause codes and the packed structs
  that travel between the controller blocks
*/
`include "ctrl_settings.svh"

package ctrl_pkg;

  ////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////

  // Main controller states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FUNCTIONAL,
    SLEEP,
    DEBUG_TAKEN
  } ctrl_state_e;

  // PC source select towards IF
  typedef enum logic [3:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_TRAP_EXC,
    PC_TRAP_IRQ,
    PC_TRAP_DBD,
    PC_TRAP_DBE,
    PC_DRET,
    PC_FENCEI
  } pc_mux_e;

  // Synchronous exception causes
  typedef enum logic [`CTRL_EXC_CODE_W-1:0] {
    INSTR_FAULT  = `CTRL_EXC_INSTR_FAULT,
    ILLEGAL_INSN = `CTRL_EXC_ILLEGAL_INSN,
    BREAKPOINT   = `CTRL_EXC_BREAKPOINT,
    LOAD_FAULT   = `CTRL_EXC_LOAD_FAULT,
    STORE_FAULT  = `CTRL_EXC_STORE_FAULT,
    ECALL_MMODE  = `CTRL_EXC_ECALL_MMODE
  } exc_cause_e;

  // Protection status reported by the LSU in WB
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  // Debug run status, one-hot
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } debug_state_e;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Instruction sitting in writeback
  typedef struct packed {
    logic instr_valid;
    logic instr_fault;
    logic illegal;
    logic ecall;
    logic ebreak;
    logic wfi;
    logic fencei;
    logic dret;
  } wb_pipe_t;

  // ID stage hazards
  typedef struct packed {
    logic jr_stall;
    logic load_stall;
    logic csr_stall;
  } stall_t;

  // Qualified writeback events
  typedef struct packed {
    logic       exception;
    exc_cause_e exc_code;
    logic       wfi;
    logic       fencei;
    logic       dret;
  } wb_event_t;

  // Trap decision from the arbiter
  typedef struct packed {
    logic                      take_irq;
    logic                      take_debug;
    logic                      hold_id;
    logic [`CTRL_IRQ_ID_W-1:0] irq_id;
    logic                      wake;
  } trap_req_t;

  // mcause value
  typedef struct packed {
    logic                        interrupt;
    logic [`CTRL_EXC_CODE_W-1:0] exception_code;
  } cause_t;

  // Everything the controller hands to the pipeline
  typedef struct packed {
    logic    instr_req;
    logic    ctrl_busy;
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    kill_if;
    logic    kill_id;
    logic    kill_ex;
    logic    kill_wb;
    logic    halt_if;
    logic    halt_id;
    logic    halt_ex;
    logic    halt_wb;
    logic    irq_ack;
    logic    dbg_ack;
    logic    csr_save_cause;
    cause_t  csr_cause;
    logic    debug_mode;
  } ctrl_out_t;

endpackage

// ==== include/ctrl_settings.svh ====
/*
  Pipeline controller settings
  Field widths and the RISC-V exception codes used by the controller
*/
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// Interrupt id width, matches the interrupt controller
`define CTRL_IRQ_ID_W 5
// mcause exception code width
`define CTRL_EXC_CODE_W 8

// Exception codes as written to mcause
`define CTRL_EXC_INSTR_FAULT 8'h01
`define CTRL_EXC_ILLEGAL_INSN 8'h02
`define CTRL_EXC_BREAKPOINT 8'h03
`define CTRL_EXC_LOAD_FAULT 8'h05
`define CTRL_EXC_STORE_FAULT 8'h07
`define CTRL_EXC_ECALL_MMODE 8'h0B

`endif
